/* hdl/conv_pkg.sv */
// --------------------------------------------------
// shared types and fixed configuration widths
// matrix size port is 14 bits, shift port is 6 bits
// --------------------------------------------------
package conv_pkg;

  // --------------------------------------------------
  // activation functions
  // --------------------------------------------------

  // applied after the shift and the wrap to Bits
  typedef enum logic [1:0] {
    // value passes through unchanged
    ACT_NONE  = 2'd0,
    // negative values become zero
    ACT_RELU  = 2'd1,
    // negative values are scaled down by LeakyShift
    ACT_LEAKY = 2'd2,
    // limited to zero .. half of the positive range
    ACT_CLAMP = 2'd3
  } act_func_e;

  // --------------------------------------------------
  // configuration widths
  // --------------------------------------------------

  // matrix edge length, one square matrix per run
  localparam int unsigned MatrixSizeW = 14;

  // arithmetic right shift applied to the full sum
  localparam int unsigned ShiftW = 6;

  // leaky slope is 1/8 for negative values
  localparam int unsigned LeakyShift = 3;

endpackage

/* hdl/window_if.sv */
// --------------------------------------------------
// one KernelSize x KernelSize window per item
// item moves when win_valid and win_take are high
// --------------------------------------------------
`timescale 1ns/10ps

interface window_if #(
  parameter int unsigned KernelSize = 3,
  parameter int unsigned Bits       = 8
);

  // pixel (r, c) sits at slice (r*KernelSize + c)*Bits, row 0 is the oldest row
  logic [KernelSize*KernelSize*Bits-1:0] win;
  // window register holds an item
  logic                                  win_valid;
  // final window of the matrix
  logic                                  win_last;
  // engine 0 accepts, all engines follow in lockstep
  logic                                  win_take;

  // window generator side
  modport gen (output win, output win_valid, output win_last, input win_take);

  // engine side, only engine 0 drives win_take
  modport eng (input win, input win_valid, input win_last, output win_take);

endinterface

/* hdl/line_window.sv */
// --------------------------------------------------
// pixel stream to sliding windows, stride 1, no pad
// needs KernelSize >= 2 and MaxMatrixSize < 2**14
// expects exactly matrix_size_i**2 pixels per run
// --------------------------------------------------
`timescale 1ns/10ps

module line_window #(
  parameter int unsigned MaxMatrixSize = 64,
  parameter int unsigned KernelSize    = 3,
  parameter int unsigned Bits          = 8
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             running_i,
  input  logic [conv_pkg::MatrixSizeW-1:0] matrix_size_i,
  input  logic                             has_data_i,
  input  logic signed [Bits-1:0]           activation_data_i,
  output logic                             used_data_o,
  window_if.gen                            win_if
);
  import conv_pkg::*;

  localparam int unsigned AddrW = (MaxMatrixSize > 1) ? $clog2(MaxMatrixSize) : 1;
  localparam logic [MatrixSizeW-1:0] EdgeMin = MatrixSizeW'(KernelSize - 1);

  // line_mem[0] holds the previous row, line_mem[k] the row k+1 above
  logic [Bits-1:0]        line_mem [KernelSize-1][MaxMatrixSize];
  logic [Bits-1:0]        win_reg  [KernelSize][KernelSize];
  logic [Bits-1:0]        new_col  [KernelSize];
  logic [MatrixSizeW-1:0] col_q;
  logic [MatrixSizeW-1:0] row_q;
  logic [AddrW-1:0]       addr;
  logic                   last_col;
  logic                   last_row;
  logic                   complete;
  logic                   accept;

  // --------------------------------------------------
  // pixel handshake
  // --------------------------------------------------

  // window stage must be empty or leaving this cycle
  assign accept      = has_data_i && running_i && (!win_if.win_valid || win_if.win_take);
  assign used_data_o = accept;

  assign addr     = col_q[AddrW-1:0];
  assign last_col = (col_q == matrix_size_i - 1'b1);
  assign last_row = (row_q == matrix_size_i - 1'b1);
  // pixel closes a window once a full kernel fits above and left of it
  assign complete = (col_q >= EdgeMin) && (row_q >= EdgeMin);

  // newest column, bottom entry is the incoming pixel
  always_comb begin
    new_col[KernelSize-1] = activation_data_i;
    for (int k = 0; k < KernelSize - 1; k++) begin
      new_col[KernelSize-2-k] = line_mem[k][addr];
    end
  end

  // --------------------------------------------------
  // line buffers and window shift
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      line_mem[0][addr] <= activation_data_i;
      // each row moves one buffer further up
      for (int k = 1; k < KernelSize - 1; k++) begin
        line_mem[k][addr] <= line_mem[k-1][addr];
      end
      // columns slide left, new column enters on the right
      for (int r = 0; r < KernelSize; r++) begin
        for (int c = 0; c < KernelSize - 1; c++) begin
          win_reg[r][c] <= win_reg[r][c+1];
        end
        win_reg[r][KernelSize-1] <= new_col[r];
      end
    end
  end

  // position counters and window valid
  always_ff @(posedge clk_i) begin
    if (reset_i || !running_i) begin
      col_q            <= '0;
      row_q            <= '0;
      win_if.win_valid <= 1'b0;
      win_if.win_last  <= 1'b0;
    end else if (accept) begin
      win_if.win_valid <= complete;
      win_if.win_last  <= last_col && last_row;
      if (last_col) begin
        col_q <= '0;
        row_q <= row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end else if (win_if.win_take) begin
      win_if.win_valid <= 1'b0;
    end
  end

  // flatten the window row by row
  for (genvar r = 0; r < KernelSize; r++) begin : g_row
    for (genvar c = 0; c < KernelSize; c++) begin : g_col
      assign win_if.win[(r*KernelSize+c)*Bits +: Bits] = win_reg[r][c];
    end
  end

endmodule

/* hdl/conv_engine.sv */
// --------------------------------------------------
// one kernel against the shared window, 2 stages
// sum is full width, shift is arithmetic, wraps to Bits
// needs Bits >= 3, only EngineIndex 0 drives win_take
// --------------------------------------------------
`timescale 1ns/10ps

module conv_engine #(
  parameter int unsigned KernelSize  = 3,
  parameter int unsigned Bits        = 8,
  parameter int unsigned EngineCount = 4,
  parameter int unsigned EngineIndex = 0
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 running_i,
  window_if.eng                                win_if,
  input  logic [KernelSize*KernelSize*Bits-1:0] weights_i,
  input  logic [$clog2(EngineCount+1)-1:0]     active_engines_i,
  input  logic [conv_pkg::ShiftW-1:0]          shift_i,
  input  conv_pkg::act_func_e                  act_func_i,
  input  logic                                 out_take_i,
  output logic signed [Bits-1:0]               result_o,
  output logic                                 result_valid_o,
  output logic                                 result_last_o
);
  import conv_pkg::*;

  localparam int unsigned Taps = KernelSize * KernelSize;
  // products are 2*Bits, the tap sum adds clog2(Taps) bits of growth
  localparam int unsigned SumW = 2 * Bits + $clog2(Taps);
  // half of the positive range
  localparam logic signed [Bits-1:0] ClampMax = {2'b00, {(Bits-2){1'b1}}};

  logic signed [SumW-1:0] mac_sum;
  logic signed [SumW-1:0] s1_sum;
  logic signed [SumW-1:0] shifted;
  logic signed [Bits-1:0] wrapped;
  logic signed [Bits-1:0] activated;
  logic                   s1_valid;
  logic                   s1_last;
  logic                   s2_valid;
  logic                   s2_last;
  logic                   s1_adv;
  logic                   s2_adv;
  logic                   lane_on;

  // --------------------------------------------------
  // stage 1, multiply-accumulate
  // --------------------------------------------------
  always_comb begin
    mac_sum = '0;
    for (int t = 0; t < Taps; t++) begin
      mac_sum += SumW'($signed(win_if.win[t*Bits +: Bits]) * $signed(weights_i[t*Bits +: Bits]));
    end
  end

  // --------------------------------------------------
  // stage 2, shift, wrap and activation
  // --------------------------------------------------
  assign shifted = s1_sum >>> shift_i;
  // only the low Bits survive, upper bits are dropped
  assign wrapped = shifted[Bits-1:0];
  assign lane_on = (active_engines_i > EngineIndex);

  always_comb begin
    case (act_func_i)
      ACT_RELU:  activated = wrapped[Bits-1] ? '0 : wrapped;
      ACT_LEAKY: activated = wrapped[Bits-1] ? (wrapped >>> LeakyShift) : wrapped;
      ACT_CLAMP: begin
        if (wrapped[Bits-1]) begin
          activated = '0;
        end else if (wrapped > ClampMax) begin
          activated = ClampMax;
        end else begin
          activated = wrapped;
        end
      end
      default:   activated = wrapped;
    endcase
  end

  // a stage moves when the one after it is empty or moving
  assign s2_adv = !s2_valid || out_take_i;
  assign s1_adv = !s1_valid || s2_adv;

  always_ff @(posedge clk_i) begin
    if (reset_i || !running_i) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      if (s1_adv) begin
        s1_valid <= win_if.win_valid;
        s1_last  <= win_if.win_valid && win_if.win_last;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
        s2_last  <= s1_last;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_adv && win_if.win_valid) begin
      s1_sum <= mac_sum;
    end
    // inactive lanes still step but present zero
    if (s2_adv && s1_valid) begin
      result_o <= lane_on ? activated : '0;
    end
  end

  assign result_valid_o = s2_valid;
  assign result_last_o  = s2_last;

  // all engines share the same stage state, engine 0 speaks for them
  if (EngineIndex == 0) begin : g_take
    assign win_if.win_take = s1_adv;
  end

endmodule

/* hdl/conv_control.sv */
// --------------------------------------------------
// run flag, config capture and output register
// config is sampled on start only, later changes ignored
// start is ignored while a run is in progress
// --------------------------------------------------
`timescale 1ns/10ps

module conv_control #(
  parameter int unsigned KernelSize  = 3,
  parameter int unsigned Bits        = 8,
  parameter int unsigned EngineCount = 4
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                                             start_i,
  input  logic [EngineCount*KernelSize*KernelSize*Bits-1:0] kernel_weights_i,
  input  logic [conv_pkg::MatrixSizeW-1:0]                 matrix_size_i,
  input  logic [$clog2(EngineCount+1)-1:0]                 active_engines_i,
  input  logic [conv_pkg::ShiftW-1:0]                      shift_i,
  input  conv_pkg::act_func_e                              act_func_i,
  output logic [conv_pkg::MatrixSizeW-1:0]                 matrix_size_o,
  output logic [$clog2(EngineCount+1)-1:0]                 active_engines_o,
  output logic [conv_pkg::ShiftW-1:0]                      shift_o,
  output conv_pkg::act_func_e                              act_func_o,
  output logic [EngineCount*KernelSize*KernelSize*Bits-1:0] weights_o,
  input  logic [EngineCount*Bits-1:0]                      eng_result_i,
  input  logic                                             eng_valid_i,
  input  logic                                             eng_last_i,
  output logic                                             out_take_o,
  input  logic                                             req_next_i,
  output logic                                             conv_valid_o,
  output logic [EngineCount*Bits-1:0]                      data_o,
  output logic                                             conv_done_o,
  output logic                                             conv_running_o
);

  logic capture;
  logic out_release;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign capture     = start_i && !conv_running_o;
  assign out_release = conv_valid_o && req_next_i;
  // load when the output register is empty or being consumed
  assign out_take_o  = eng_valid_i && (!conv_valid_o || req_next_i);

  // running from the cycle after start until the last output is taken
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      conv_running_o <= 1'b0;
    end else if (capture) begin
      conv_running_o <= 1'b1;
    end else if (out_release && conv_done_o) begin
      conv_running_o <= 1'b0;
    end
  end

  // configuration snapshot
  always_ff @(posedge clk_i) begin
    if (capture) begin
      matrix_size_o    <= matrix_size_i;
      active_engines_o <= active_engines_i;
      shift_o          <= shift_i;
      act_func_o       <= act_func_i;
      weights_o        <= kernel_weights_i;
    end
  end

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || !conv_running_o) begin
      conv_valid_o <= 1'b0;
      conv_done_o  <= 1'b0;
    end else if (out_take_o) begin
      conv_valid_o <= 1'b1;
      conv_done_o  <= eng_last_i;
    end else if (out_release) begin
      conv_valid_o <= 1'b0;
      conv_done_o  <= 1'b0;
    end
  end

  // held while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (out_take_o) begin
      data_o <= eng_result_i;
    end
  end

endmodule

/* hdl/conv_layer.sv */
// --------------------------------------------------
// streaming 2-D conv layer, EngineCount kernels in parallel
// KernelSize <= matrix_size_i <= MaxMatrixSize < 2**14
// active_engines_i <= EngineCount, Bits >= 3, KernelSize >= 2
// --------------------------------------------------
`timescale 1ns/10ps

module conv_layer #(
  parameter int unsigned MaxMatrixSize = 64,
  parameter int unsigned KernelSize    = 3,
  parameter int unsigned EngineCount   = 4,
  parameter int unsigned Bits          = 8
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                                             start_i,
  input  logic [EngineCount*KernelSize*KernelSize*Bits-1:0] kernel_weights_i,
  input  logic [conv_pkg::MatrixSizeW-1:0]                 matrix_size_i,
  input  logic [$clog2(EngineCount+1)-1:0]                 active_engines_i,
  input  logic [conv_pkg::ShiftW-1:0]                      shift_i,
  input  conv_pkg::act_func_e                              act_func_i,
  input  logic                                             has_data_i,
  input  logic signed [Bits-1:0]                           activation_data_i,
  output logic                                             used_data_o,
  output logic                                             conv_valid_o,
  output logic [EngineCount*Bits-1:0]                      data_o,
  output logic                                             conv_done_o,
  output logic                                             conv_running_o,
  input  logic                                             req_next_i
);
  import conv_pkg::*;

  localparam int unsigned KernW   = KernelSize * KernelSize * Bits;
  localparam int unsigned ActiveW = $clog2(EngineCount + 1);

  // captured configuration
  logic [MatrixSizeW-1:0]       cfg_matrix_size;
  logic [ActiveW-1:0]           cfg_active;
  logic [ShiftW-1:0]            cfg_shift;
  act_func_e                    cfg_act;
  logic [EngineCount*KernW-1:0] cfg_weights;

  // engine lanes, only lane 0 valid and last reach control
  logic [EngineCount*Bits-1:0]  eng_result;
  logic [EngineCount-1:0]       lane_valid;
  logic [EngineCount-1:0]       lane_last;
  logic                         out_take;

  window_if #(.KernelSize(KernelSize), .Bits(Bits)) win_bus ();

  // --------------------------------------------------
  // control and window generator
  // --------------------------------------------------
  conv_control #(
    .KernelSize (KernelSize),
    .Bits       (Bits),
    .EngineCount(EngineCount)
  ) u_control (
    .clk_i, .reset_i, .start_i, .kernel_weights_i,
    .matrix_size_i, .active_engines_i, .shift_i, .act_func_i,
    .matrix_size_o   (cfg_matrix_size),
    .active_engines_o(cfg_active),
    .shift_o         (cfg_shift),
    .act_func_o      (cfg_act),
    .weights_o       (cfg_weights),
    .eng_result_i    (eng_result),
    .eng_valid_i     (lane_valid[0]),
    .eng_last_i      (lane_last[0]),
    .out_take_o      (out_take),
    .req_next_i, .conv_valid_o, .data_o, .conv_done_o, .conv_running_o
  );

  line_window #(
    .MaxMatrixSize(MaxMatrixSize),
    .KernelSize   (KernelSize),
    .Bits         (Bits)
  ) u_window (
    .clk_i, .reset_i,
    .running_i    (conv_running_o),
    .matrix_size_i(cfg_matrix_size),
    .has_data_i, .activation_data_i, .used_data_o,
    .win_if       (win_bus.gen)
  );

  // --------------------------------------------------
  // engines, one kernel each
  // --------------------------------------------------
  for (genvar e = 0; e < EngineCount; e++) begin : g_engine
    conv_engine #(
      .KernelSize (KernelSize),
      .Bits       (Bits),
      .EngineCount(EngineCount),
      .EngineIndex(e)
    ) u_engine (
      .clk_i, .reset_i,
      .running_i       (conv_running_o),
      .win_if          (win_bus.eng),
      .weights_i       (cfg_weights[e*KernW +: KernW]),
      .active_engines_i(cfg_active),
      .shift_i         (cfg_shift),
      .act_func_i      (cfg_act),
      .out_take_i      (out_take),
      .result_o        (eng_result[e*Bits +: Bits]),
      .result_valid_o  (lane_valid[e]),
      .result_last_o   (lane_last[e])
    );
  end

endmodule

/* test/conv_layer_sva.sv */
// --------------------------------------------------
// handshake assertions bound to every conv_layer
// DataW must match EngineCount*Bits of the target
// --------------------------------------------------
`timescale 1ns/10ps

module conv_layer_sva #(
  parameter int unsigned DataW = 32
) (
  input logic             clk_i,
  input logic             reset_i,
  input logic             has_data_i,
  input logic             used_data_o,
  input logic             conv_running_o,
  input logic             conv_valid_o,
  input logic             conv_done_o,
  input logic             req_next_i,
  input logic [DataW-1:0] data_o
);

  // failed assertions so far, read by the testbench
  int unsigned fail_count = 0;

  // a pixel is only consumed when offered during a run
  used_needs_source: assert property (@(posedge clk_i) disable iff (reset_i)
    used_data_o |-> (has_data_i && conv_running_o))
    else begin
      $error("used_data_o high without has_data_i or outside a run");
      fail_count++;
    end

  // held output must not move under back-pressure
  hold_under_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    (conv_valid_o && !req_next_i) |=> ($stable(data_o) && $stable(conv_done_o)))
    else begin
      $error("data_o or conv_done_o changed while stalled");
      fail_count++;
    end

  // no output outside a run
  valid_needs_run: assert property (@(posedge clk_i) disable iff (reset_i)
    !conv_running_o |-> !conv_valid_o)
    else begin
      $error("conv_valid_o high while not running");
      fail_count++;
    end

endmodule

bind conv_layer conv_layer_sva #(.DataW(EngineCount*Bits)) u_sva (
  .clk_i, .reset_i, .has_data_i, .used_data_o, .conv_running_o,
  .conv_valid_o, .conv_done_o, .req_next_i, .data_o
);

/* test/conv_layer_tb.sv */
// --------------------------------------------------
// random matrices and kernels against a lane model
// inputs change 1 ns after the rising edge
// outputs are sampled on the falling edge
// --------------------------------------------------
`timescale 1ns/10ps

module conv_layer_tb;
  import conv_pkg::*;

  localparam int unsigned MaxMatrixSize = 16;
  localparam int unsigned KernelSize    = 3;
  localparam int unsigned EngineCount   = 4;
  localparam int unsigned Bits          = 8;
  localparam int unsigned Taps          = KernelSize * KernelSize;
  localparam int unsigned ActiveW       = $clog2(EngineCount + 1);
  // half of the positive range
  localparam int          ClampMax      = (2 ** (Bits - 1) - 1) / 2;

  logic                          clk_i;
  logic                          reset_i;
  logic                          start_i;
  logic [EngineCount*Taps*Bits-1:0] kernel_weights_i;
  logic [MatrixSizeW-1:0]        matrix_size_i;
  logic [ActiveW-1:0]            active_engines_i;
  logic [ShiftW-1:0]             shift_i;
  act_func_e                     act_func_i;
  logic                          has_data_i;
  logic signed [Bits-1:0]        activation_data_i;
  logic                          used_data_o;
  logic                          conv_valid_o;
  logic [EngineCount*Bits-1:0]   data_o;
  logic                          conv_done_o;
  logic                          conv_running_o;
  logic                          req_next_i;

  int errors;
  int checks;
  int tests_passed;
  int tests_failed;
  int err_mark;
  int sva_mark;
  // model state of the current run
  int pix [MaxMatrixSize*MaxMatrixSize];
  int wgt [EngineCount][Taps];
  logic [EngineCount*Bits-1:0] exp_q [$];

  conv_layer #(
    .MaxMatrixSize(MaxMatrixSize),
    .KernelSize   (KernelSize),
    .EngineCount  (EngineCount),
    .Bits         (Bits)
  ) uut (
    .clk_i, .reset_i, .start_i, .kernel_weights_i, .matrix_size_i,
    .active_engines_i, .shift_i, .act_func_i, .has_data_i, .activation_data_i,
    .used_data_o, .conv_valid_o, .data_o, .conv_done_o, .conv_running_o, .req_next_i
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic int activate(input int v, input act_func_e act);
    case (act)
      ACT_RELU:  return (v < 0) ? 0 : v;
      ACT_LEAKY: return (v < 0) ? (v >>> LeakyShift) : v;
      ACT_CLAMP: return (v < 0) ? 0 : ((v > ClampMax) ? ClampMax : v);
      default:   return v;
    endcase
  endfunction

  // one lane of the window whose top-left pixel is (i, j)
  function automatic logic [Bits-1:0] lane_model(input int i, input int j, input int n,
                                                 input int e, input int sh,
                                                 input act_func_e act);
    int sum;
    int s;
    logic signed [Bits-1:0] wrapped;
    sum = 0;
    for (int r = 0; r < KernelSize; r++) begin
      for (int c = 0; c < KernelSize; c++) begin
        sum += pix[(i + r) * n + j + c] * wgt[e][r * KernelSize + c];
      end
    end
    // beyond 31 the result is pure sign fill anyway
    s = sum >>> ((sh > 31) ? 31 : sh);
    wrapped = s[Bits-1:0];
    return Bits'(activate(int'(wrapped), act));
  endfunction

  // --------------------------------------------------
  // checks and reporting
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input string name);
    if (uut.u_sva.fail_count != sva_mark) begin
      note_error("a bound handshake assertion failed during this test");
      sva_mark = uut.u_sva.fail_count;
    end
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // --------------------------------------------------
  // one full run of start, pixel stream and output drain
  // --------------------------------------------------
  task automatic run_conv(input int n, input int sh, input act_func_e act, input int active,
                          input int gap_pct, input int stall_pct, input bit scramble);
    logic signed [Bits-1:0] rnd;
    logic [EngineCount*Bits-1:0] word;
    int total;
    int n_out;
    int idx;
    int outs;
    int cycles;
    int limit;
    bit done_seen;
    bit finished;
    total = n * n;
    n_out = (n - KernelSize + 1) * (n - KernelSize + 1);
    idx = 0;
    outs = 0;
    cycles = 0;
    limit = total * 20 + 200;
    done_seen = 0;
    finished = 0;
    for (int p = 0; p < total; p++) begin
      rnd = $urandom;
      pix[p] = rnd;
    end
    for (int e = 0; e < EngineCount; e++) begin
      for (int t = 0; t < Taps; t++) begin
        rnd = $urandom;
        wgt[e][t] = rnd;
      end
    end
    // expected words in row-major window order
    exp_q.delete();
    for (int i = 0; i <= n - KernelSize; i++) begin
      for (int j = 0; j <= n - KernelSize; j++) begin
        for (int e = 0; e < EngineCount; e++) begin
          word[e*Bits +: Bits] = (e < active) ? lane_model(i, j, n, e, sh, act) : '0;
        end
        exp_q.push_back(word);
      end
    end
    @(posedge clk_i);
    #1;
    matrix_size_i    = MatrixSizeW'(n);
    active_engines_i = ActiveW'(active);
    shift_i          = ShiftW'(sh);
    act_func_i       = act;
    for (int e = 0; e < EngineCount; e++) begin
      for (int t = 0; t < Taps; t++) begin
        kernel_weights_i[(e * Taps + t) * Bits +: Bits] = wgt[e][t][Bits-1:0];
      end
    end
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    while (!finished && cycles < limit) begin
      has_data_i        = (idx < total) && ($urandom_range(99) >= gap_pct);
      activation_data_i = (idx < total) ? pix[idx][Bits-1:0] : '0;
      req_next_i        = ($urandom_range(99) >= stall_pct);
      // captured copies must shield the run from these
      if (scramble) begin
        matrix_size_i    = MatrixSizeW'($urandom);
        active_engines_i = ActiveW'($urandom);
        shift_i          = ShiftW'($urandom);
        act_func_i       = act_func_e'($urandom_range(3));
        for (int k = 0; k < EngineCount * Taps; k++) begin
          kernel_weights_i[k*Bits +: Bits] = Bits'($urandom);
        end
      end
      @(negedge clk_i);
      if (done_seen) begin
        // the run ends one cycle after the last output is consumed
        check_value("conv_running_o", 0, conv_running_o);
        finished = 1;
      end else begin
        if (used_data_o) begin
          idx++;
        end
        if (conv_valid_o && req_next_i) begin
          if (exp_q.size() == 0) begin
            note_error("more outputs than windows in the matrix");
          end else begin
            word = exp_q.pop_front();
            check_value("data_o", word, data_o);
            check_value("conv_done_o", exp_q.size() == 0, conv_done_o);
            done_seen = conv_done_o;
            outs++;
          end
        end
      end
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!finished) begin
      note_error($sformatf("timeout after %0d cycles waiting for the run to end", cycles));
    end
    has_data_i = 1'b0;
    req_next_i = 1'b0;
    check_value("used_data_o pulses", total, idx);
    check_value("output count", n_out, outs);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(52));
    reset_i           = 1'b1;
    start_i           = 1'b0;
    kernel_weights_i  = '0;
    matrix_size_i     = '0;
    active_engines_i  = '0;
    shift_i           = '0;
    act_func_i        = ACT_NONE;
    has_data_i        = 1'b0;
    activation_data_i = '0;
    req_next_i        = 1'b0;
    errors            = 0;
    checks            = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    err_mark          = 0;
    sva_mark          = 0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("conv_running_o", 0, conv_running_o);
    check_value("conv_valid_o", 0, conv_valid_o);
    check_value("conv_done_o", 0, conv_done_o);

    run_conv(8, 0, ACT_NONE, EngineCount, 0, 0, 0);
    finish_test("1 plain stream");
    for (int a = 0; a < 4; a++) begin
      run_conv(8, $urandom_range(12), act_func_e'(a), EngineCount, 0, 0, 0);
    end
    finish_test("2 shift and activation");
    run_conv(10, 4, ACT_NONE, EngineCount, 40, 50, 0);
    run_conv(9, 6, ACT_LEAKY, EngineCount, 60, 30, 0);
    finish_test("3 gaps and back-pressure");
    run_conv(8, 2, ACT_RELU, 1, 0, 20, 0);
    run_conv(7, 3, ACT_NONE, $urandom_range(EngineCount - 1), 10, 10, 0);
    finish_test("4 inactive engines");
    run_conv(6, 1, ACT_CLAMP, EngineCount, 10, 10, 0);
    run_conv(11, 5, ACT_LEAKY, EngineCount, 10, 10, 0);
    finish_test("5 done marker and restart");
    run_conv(8, 3, ACT_LEAKY, 3, 20, 20, 1);
    finish_test("6 config changes while running");

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* conv_layer.f */
hdl/conv_pkg.sv
hdl/window_if.sv
hdl/line_window.sv
hdl/conv_engine.sv
hdl/conv_control.sv
hdl/conv_layer.sv
test/conv_layer_sva.sv
test/conv_layer_tb.sv

/* Bender.yml */
package:
  name: conv_layer

sources:
  # package and interface first, then the RTL bottom up
  - hdl/conv_pkg.sv
  - hdl/window_if.sv
  - hdl/line_window.sv
  - hdl/conv_engine.sv
  - hdl/conv_control.sv
  - hdl/conv_layer.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/conv_layer_sva.sv
      - test/conv_layer_tb.sv
